/* design/spi_pkg.sv */
/*
  spi framing definitions
  widths of the 16 bit mode 0 frame and the pin synchronizer depth
*/
package spi_pkg;

  ////////////////////
  // frame geometry

  // address byte then data byte, msb first
  localparam int FRAME_BITS = 16;

  // flops in each pin synchronizer
  localparam int SYNC_STAGES = 2;

  ////////////////////
  // types

  // one whole frame, address in the upper byte
  typedef logic [FRAME_BITS-1:0] frame_t;

  // one byte of the frame
  typedef logic [7:0] byte_t;

  // bits seen so far in the frame
  // 5 bits, saturates so long frames never wrap back to 16
  typedef logic [4:0] bit_cnt_t;

endpackage

/* design/regmap_pkg.sv */
/*
  control register map
  register numbers, reset values and register widths
*/
package regmap_pkg;

  ////////////////////
  // types

  // register number, addr byte without the write flag
  typedef logic [6:0] reg_addr_t;

  // nibble register, set/clear/toggle in one write
  typedef logic [3:0] nib_t;

  // number of external peripherals behind the second select
  localparam int N_PERIPH = 8;

  // one bit per peripheral
  typedef logic [N_PERIPH-1:0] periph_vec_t;

  ////////////////////
  // register numbers

  // status led nibble
  localparam reg_addr_t REG_LED = 7'd7;

  // peripheral routing, 0 selects nothing
  localparam reg_addr_t REG_ROUTE = 7'd8;

  // auxiliary outputs nibble
  localparam reg_addr_t REG_AUX = 7'd9;

  // any write here restores the defaults
  localparam reg_addr_t REG_SOFT_RST = 7'd11;

  ////////////////////
  // reset values

  // led 0 lit so the board shows it is configured
  localparam nib_t LED_RST_VAL = 4'b0001;

endpackage

/* design/spi_frame_rx.sv */
`timescale 1ns/1ps

/*
  spi frame receiver
  oversamples the mode 0 pins in the cs domain, shifts in a 16 bit frame
  and shifts the read-back byte out during the data byte
*/
module spi_frame_rx
  import spi_pkg::*;
(
  input  logic   cs,
  input  logic   arst_n,
  input  logic   sclk,
  input  logic   ss_n,
  input  logic   mosi,
  input  byte_t  rd_data,
  output logic   addr_valid,
  output byte_t  addr,
  output logic   frame_done,
  output frame_t frame,
  output logic   bank_miso
);

  // count values of interest
  localparam bit_cnt_t ADDR_LAST = bit_cnt_t'(FRAME_BITS / 2 - 1);
  localparam bit_cnt_t FRAME_LEN = bit_cnt_t'(FRAME_BITS);
  localparam bit_cnt_t CNT_MAX = '1;

  logic [SYNC_STAGES-1:0] sclk_sync;
  logic [SYNC_STAGES-1:0] ss_n_sync;
  logic [SYNC_STAGES-1:0] mosi_sync;
  logic                   sclk_d;
  logic                   ss_n_d;
  logic                   sclk_s;
  logic                   ss_n_s;
  logic                   mosi_s;
  logic                   sclk_rise;
  logic                   sclk_fall;
  logic                   ss_rise;
  logic                   load_tx;
  bit_cnt_t               bit_cnt;
  frame_t                 shift_q;
  byte_t                  tx_shift;

  ////////////////////
  // pin synchronizers

  // ss_n idles high so its chain resets to ones
  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      sclk_sync <= '0;
      ss_n_sync <= '1;
      mosi_sync <= '0;
      sclk_d    <= 1'b0;
      ss_n_d    <= 1'b1;
    end
    else
    begin
      sclk_sync <= {sclk_sync[SYNC_STAGES-2:0], sclk};
      ss_n_sync <= {ss_n_sync[SYNC_STAGES-2:0], ss_n};
      mosi_sync <= {mosi_sync[SYNC_STAGES-2:0], mosi};
      sclk_d    <= sclk_s;
      ss_n_d    <= ss_n_s;
    end
  end

  assign sclk_s = sclk_sync[SYNC_STAGES-1];
  assign ss_n_s = ss_n_sync[SYNC_STAGES-1];
  assign mosi_s = mosi_sync[SYNC_STAGES-1];

  // sclk edges only count while selected
  assign sclk_rise = sclk_s & ~sclk_d & ~ss_n_s;
  assign sclk_fall = ~sclk_s & sclk_d & ~ss_n_s;
  assign ss_rise   = ss_n_s & ~ss_n_d;

  ////////////////////
  // receive side

  // bit counter cleared while deselected
  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
      bit_cnt <= '0;
    else if (ss_n_s)
      bit_cnt <= '0;
    else if (sclk_rise && bit_cnt != CNT_MAX)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // mosi sampled on rising sclk with the msb landing on top
  always_ff @(posedge cs)
  begin
    if (sclk_rise)
      shift_q <= {shift_q[FRAME_BITS-2:0], mosi_s};
  end

  // count still holds the old value when the pulses are set
  // frame_done only for exactly 16 bits
  // any other length is dropped
  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      addr_valid <= 1'b0;
      frame_done <= 1'b0;
      load_tx    <= 1'b0;
    end
    else
    begin
      addr_valid <= sclk_rise && (bit_cnt == ADDR_LAST);
      frame_done <= ss_rise && (bit_cnt == FRAME_LEN);
      // rd_data is ready one cycle after addr_valid
      load_tx    <= addr_valid;
    end
  end

  assign addr  = shift_q[$bits(byte_t)-1:0];
  assign frame = shift_q;

  ////////////////////
  // transmit side

  // zeros go out during the address byte
  // load lands well before the first falling edge of the data byte
  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tx_shift  <= '0;
      bank_miso <= 1'b0;
    end
    else if (ss_n_s)
    begin
      tx_shift  <= '0;
      bank_miso <= 1'b0;
    end
    else if (load_tx)
      tx_shift <= rd_data;
    else if (sclk_fall)
    begin
      bank_miso <= tx_shift[$bits(byte_t)-1];
      tx_shift  <= {tx_shift[$bits(byte_t)-2:0], 1'b0};
    end
  end

  // read-back load must land between sclk edges
  // a host toggling sclk too fast would drop the first shift
  a_load_clear: assert property (@(posedge cs) disable iff (!arst_n)
    !(load_tx && sclk_fall));

endmodule

/* design/reg_file.sv */
`timescale 1ns/1ps

/*
  control register file
  nibble registers with set/clear/toggle writes, the route byte,
  the read-back mux and the soft reset command
*/
module reg_file
  import spi_pkg::*, regmap_pkg::*;
(
  input  logic   cs,
  input  logic   arst_n,
  input  logic   addr_valid,
  input  byte_t  addr,
  input  logic   frame_done,
  input  frame_t frame,
  output byte_t  rd_data,
  output nib_t   led,
  output nib_t   aux,
  output byte_t  route
);

  reg_addr_t rd_addr;
  reg_addr_t wr_addr;
  byte_t     wr_data;
  logic      wr_en;
  nib_t      set_mask;
  nib_t      clr_mask;

  ////////////////////
  // nibble update

  // overlap of both masks toggles only the overlapping bits
  // otherwise set first, then clear
  function automatic nib_t nib_update(
    input nib_t cur,
    input nib_t set_m,
    input nib_t clr_m
  );
    nib_t both;
    begin
      both = set_m & clr_m;
      if (both != '0)
        nib_update = cur ^ both;
      else
        nib_update = (cur | set_m) & ~clr_m;
    end
  endfunction

  ////////////////////
  // frame decode

  // bit 7 of the addr byte is the write flag
  assign rd_addr = addr[$bits(reg_addr_t)-1:0];

  // upper byte is addr, lower byte is data
  assign wr_en   = frame_done & frame[FRAME_BITS-1];
  assign wr_addr = frame[FRAME_BITS-2 -: $bits(reg_addr_t)];
  assign wr_data = frame[$bits(byte_t)-1:0];

  // low nibble sets, high nibble clears
  assign set_mask = wr_data[3:0];
  assign clr_mask = wr_data[7:4];

  ////////////////////
  // read mux

  // registered on addr_valid, frame rx picks it up next cycle
  // nibbles come back zero-extended
  always_ff @(posedge cs)
  begin
    if (addr_valid)
    begin
      case (rd_addr)
        REG_LED:   rd_data <= byte_t'(led);
        REG_AUX:   rd_data <= byte_t'(aux);
        REG_ROUTE: rd_data <= route;
        default:   rd_data <= '0;
      endcase
    end
  end

  ////////////////////
  // register writes

  // applied the cycle after frame_done
  always_ff @(posedge cs or negedge arst_n)
  begin
    if (!arst_n)
    begin
      led   <= LED_RST_VAL;
      aux   <= '0;
      route <= '0;
    end
    else if (wr_en)
    begin
      case (wr_addr)
        REG_LED:
          led <= nib_update(led, set_mask, clr_mask);
        REG_AUX:
          aux <= nib_update(aux, set_mask, clr_mask);
        // route byte taken as written
        REG_ROUTE:
          route <= wr_data;
        // soft reset, data byte ignored
        REG_SOFT_RST:
        begin
          led   <= LED_RST_VAL;
          aux   <= '0;
          route <= '0;
        end
        default:
        begin
          // unmapped addresses write nothing
        end
      endcase
    end
  end

  // led drives a pin, must stay known once out of reset
  a_led_known: assert property (@(posedge cs) disable iff (!arst_n)
    !$isunknown(led));

endmodule

/* design/periph_route.sv */
`timescale 1ns/1ps

/*
  peripheral routing
  turns the route byte into one polarity-adjusted select and
  brings the selected peripheral's miso back to the host
*/
module periph_route
  import spi_pkg::*, regmap_pkg::*;
#(
  parameter periph_vec_t SS_POLARITY = '0
)
(
  input  byte_t       route,
  input  logic        sel_n,
  input  logic        bank_miso,
  input  periph_vec_t periph_miso,
  output periph_vec_t periph_ss,
  output logic        miso
);

  periph_vec_t sel_hit;
  periph_vec_t ss_active;

  ////////////////////
  // decode

  // route n selects peripheral n-1
  // 0 and above 8 select none
  always_comb
  begin
    for (int i = 0; i < N_PERIPH; i++)
      sel_hit[i] = (route == byte_t'(i + 1));
  end

  // second select is active low from the host
  assign ss_active = sel_hit & {N_PERIPH{~sel_n}};

  // polarity bit set means active high
  // inactive lines sit at ~polarity
  assign periph_ss = ~(ss_active ^ SS_POLARITY);

  ////////////////////
  // miso

  // register bank answers while the second select is idle
  assign miso = sel_n ? bank_miso : |(sel_hit & periph_miso);

  // one active line for a route in range with sel_n low
  // none in every other case
  always_comb
  begin
    a_one_active: assert ($countones(periph_ss ~^ SS_POLARITY) ==
      ((!sel_n && route != '0 && route <= byte_t'(N_PERIPH)) ? 1 : 0));
  end

endmodule

/* design/spi_ctrl_top.sv */
`timescale 1ns/1ps

/*
  spi slave control block
  frame receive, register file and peripheral routing in a chain
*/
module spi_ctrl_top
  import spi_pkg::*, regmap_pkg::*;
#(
  // lines 4 to 6 are active high strobes
  parameter periph_vec_t SS_POLARITY = 8'b01110000
)
(
  input  logic        cs,
  input  logic        arst_n,
  input  logic        sclk,
  input  logic        ss_n,
  input  logic        mosi,
  input  logic        sel_n,
  input  periph_vec_t periph_miso,
  output logic        miso,
  output nib_t        led,
  output nib_t        aux,
  output periph_vec_t periph_ss
);

  logic   addr_valid;
  byte_t  addr;
  logic   frame_done;
  frame_t frame;
  byte_t  rd_data;
  byte_t  route;
  logic   bank_miso;

  ////////////////////
  // frame receive
  spi_frame_rx spi_frame_rx_i (
    .cs         (cs),
    .arst_n     (arst_n),
    .sclk       (sclk),
    .ss_n       (ss_n),
    .mosi       (mosi),
    .rd_data    (rd_data),
    .addr_valid (addr_valid),
    .addr       (addr),
    .frame_done (frame_done),
    .frame      (frame),
    .bank_miso  (bank_miso)
  );

  ////////////////////
  // registers
  reg_file reg_file_i (
    .cs         (cs),
    .arst_n     (arst_n),
    .addr_valid (addr_valid),
    .addr       (addr),
    .frame_done (frame_done),
    .frame      (frame),
    .rd_data    (rd_data),
    .led        (led),
    .aux        (aux),
    .route      (route)
  );

  ////////////////////
  // routing
  periph_route #(
    .SS_POLARITY (SS_POLARITY)
  ) periph_route_i (
    .route       (route),
    .sel_n       (sel_n),
    .bank_miso   (bank_miso),
    .periph_miso (periph_miso),
    .periph_ss   (periph_ss),
    .miso        (miso)
  );

endmodule

/* verification/spi_ctrl_checker.sv */
`timescale 1ns/1ps

/*
  spi control block checker
  compares miso over the data byte and the outputs at the end of each row
*/
module spi_ctrl_checker
  import spi_pkg::*, regmap_pkg::*;
(
  input  logic        cs,
  input  logic        sclk,
  input  logic        ss_n,
  input  logic        miso,
  input  nib_t        led,
  input  nib_t        aux,
  input  periph_vec_t periph_ss,
  input  logic        check_stb,
  input  int          row_idx,
  input  byte_t       exp_byte,
  input  nib_t        exp_led,
  input  nib_t        exp_aux,
  input  periph_vec_t exp_ss,
  output int          pass_cnt,
  output int          fail_cnt
);

  bit_cnt_t bit_idx = '0;
  int       miso_err = 0;
  int       miso_base = 0;
  int       pass_q = 0;
  int       fail_q = 0;
  int       errs;

  assign pass_cnt = pass_q;
  assign fail_cnt = fail_q;

  ////////////////////
  // miso, host side view

  // sampled on raw sclk rise, data byte is bits 8 to 15
  always @(posedge sclk or posedge ss_n)
  begin
    if (ss_n)
      bit_idx <= '0;
    else
    begin
      if (bit_idx[4:3] == 2'b01 && miso !== exp_byte[3'd7 - bit_idx[2:0]])
      begin
        $display("CHECK FAILED at %0t: row %0d miso bit %0d got %b exp %b", $time,
                 row_idx, 3'd7 - bit_idx[2:0], miso, exp_byte[3'd7 - bit_idx[2:0]]);
        miso_err <= miso_err + 1;
      end
      bit_idx <= bit_idx + 5'd1;
    end
  end

  ////////////////////
  // end of row

  // outputs have settled when the strobe comes
  always @(posedge cs)
  begin
    if (check_stb)
    begin
      errs = miso_err - miso_base;
      if (led !== exp_led)
      begin
        $display("CHECK FAILED at %0t: row %0d led got %h exp %h", $time, row_idx, led, exp_led);
        errs = errs + 1;
      end
      if (aux !== exp_aux)
      begin
        $display("CHECK FAILED at %0t: row %0d aux got %h exp %h", $time, row_idx, aux, exp_aux);
        errs = errs + 1;
      end
      if (periph_ss !== exp_ss)
      begin
        $display("CHECK FAILED at %0t: row %0d periph_ss got %b exp %b", $time, row_idx,
                 periph_ss, exp_ss);
        errs = errs + 1;
      end
      miso_base <= miso_err;
      if (errs == 0)
      begin
        pass_q <= pass_q + 1;
        $display("row %0d: pass", row_idx);
      end
      else
      begin
        fail_q <= fail_q + 1;
        $display("row %0d: fail, %0d mismatches", row_idx, errs);
      end
    end
  end

endmodule

/* verification/spi_ctrl_tb.sv */
`timescale 1ns/1ps

/*
  spi control block testbench
  plays a table of mode 0 frames into the DUT
  and spi_ctrl_checker compares the results
*/
module spi_ctrl_tb
  import spi_pkg::*, regmap_pkg::*;
();

  localparam int HALF = 5;
  localparam int SETTLE_MIN = 5;
  localparam int SETTLE_MAX = 12;
  localparam int RUN_LIMIT = 20000;
  // miso source of a row where 0 to 7 is a peripheral
  localparam logic [3:0] BANK = 4'd15;
  localparam logic [3:0] NONE = 4'd8;
  localparam bit_cnt_t FULL = 5'd16;
  localparam bit_cnt_t CUT = 5'd12;
  localparam byte_t RD_LED = {1'b0, REG_LED};
  localparam byte_t WR_LED = {1'b1, REG_LED};
  localparam byte_t RD_AUX = {1'b0, REG_AUX};
  localparam byte_t WR_AUX = {1'b1, REG_AUX};
  localparam byte_t RD_RTE = {1'b0, REG_ROUTE};
  localparam byte_t WR_RTE = {1'b1, REG_ROUTE};
  localparam byte_t WR_RST = {1'b1, REG_SOFT_RST};

  typedef struct packed {
    byte_t       addr;
    byte_t       data;
    bit_cnt_t    nbits;
    logic        sel_n;
    logic        use_lfsr;
    periph_vec_t fixed_miso;
    logic [3:0]  miso_src;
    byte_t       exp_rd;
    nib_t        exp_led;
    nib_t        exp_aux;
    periph_vec_t exp_ss;
  } row_t;

  logic        cs;
  logic        arst_n;
  logic        sclk;
  logic        ss_n;
  logic        mosi;
  logic        sel_n;
  periph_vec_t periph_miso;
  logic        miso;
  nib_t        led;
  nib_t        aux;
  periph_vec_t periph_ss;
  logic        check_stb;
  int          row_idx;
  byte_t       exp_byte;
  nib_t        exp_led;
  nib_t        exp_aux;
  periph_vec_t exp_ss;
  int          pass_cnt;
  int          fail_cnt;
  int          settle_err;
  logic [31:0] lfsr = 32'h4c32eff6;
  row_t        table_q[$];

  spi_ctrl_top spi_ctrl_top_i (
    .cs (cs), .arst_n (arst_n), .sclk (sclk), .ss_n (ss_n), .mosi (mosi),
    .sel_n (sel_n), .periph_miso (periph_miso), .miso (miso),
    .led (led), .aux (aux), .periph_ss (periph_ss)
  );

  spi_ctrl_checker checker_i (
    .cs (cs), .sclk (sclk), .ss_n (ss_n), .miso (miso), .led (led), .aux (aux),
    .periph_ss (periph_ss), .check_stb (check_stb), .row_idx (row_idx),
    .exp_byte (exp_byte), .exp_led (exp_led), .exp_aux (exp_aux), .exp_ss (exp_ss),
    .pass_cnt (pass_cnt), .fail_cnt (fail_cnt)
  );

  // 8 ns clock
  initial
  begin
    cs = 1'b0;
    forever #4 cs = ~cs;
  end

  // hang guard for the whole run
  initial
  begin
    repeat (RUN_LIMIT) @(posedge cs);
    $display("run did not finish within %0d cycles", RUN_LIMIT);
    $display("TESTBENCH FAILED");
    $finish;
  end

  ////////////////////
  // helpers

  // inputs move 1 ns after the edge
  task automatic wait_cycles(input int n);
    repeat (n) @(posedge cs);
    #1;
  endtask

  // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // one lfsr step per bit with the first bit ending up in bit 0
  task automatic draw_periph_miso(output periph_vec_t v);
    for (int k = 0; k < N_PERIPH; k++)
    begin
      v = {lfsr[0], v[N_PERIPH-1:1]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // mode 0 host drives mosi while sclk is low
  task automatic send_frame(input byte_t a, input byte_t d, input bit_cnt_t nbits);
    frame_t f;
    f = {a, d};
    ss_n = 1'b0;
    mosi = f[FRAME_BITS-1];
    for (int i = 0; i < int'(nbits); i++)
    begin
      wait_cycles(HALF);
      sclk = 1'b1;
      wait_cycles(HALF);
      sclk = 1'b0;
      f = {f[FRAME_BITS-2:0], 1'b0};
      mosi = f[FRAME_BITS-1];
    end
    wait_cycles(HALF);
    ss_n = 1'b1;
  endtask

  // bounded poll of the outputs after ss_n rises
  task automatic wait_settle(input int r);
    int   waited;
    logic done;
    waited = 0;
    done = 1'b0;
    while (!done && waited < SETTLE_MAX)
    begin
      wait_cycles(1);
      waited++;
      done = (waited >= SETTLE_MIN) && led == exp_led && aux == exp_aux && periph_ss == exp_ss;
    end
    if (!done)
    begin
      $display("row %0d: outputs did not settle within %0d cycles", r, SETTLE_MAX);
      settle_err++;
    end
  endtask

  task automatic add_row(input byte_t a, input byte_t d, input bit_cnt_t n, input logic s,
                         input logic l, input periph_vec_t fm, input logic [3:0] src,
                         input byte_t rd, input nib_t el, input nib_t ea, input periph_vec_t es);
    table_q.push_back(row_t'{a, d, n, s, l, fm, src, rd, el, ea, es});
  endtask

  ////////////////////
  // stimulus table

  // addr, data, bits, sel_n, lfsr, fixed miso, miso source, read byte, led, aux, periph_ss
  task automatic load_table();
    // defaults after reset
    add_row(RD_LED, 8'h00, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h01, 4'h1, 4'h0, 8'h8F);
    add_row(RD_AUX, 8'h00, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h00, 4'h1, 4'h0, 8'h8F);
    add_row(RD_LED, 8'h00, FULL, 1'b0, 1'b0, 8'hFF, NONE, 8'h00, 4'h1, 4'h0, 8'h8F);
    // set, clear and toggle
    // a write returns the old value
    add_row(WR_LED, 8'h06, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h01, 4'h7, 4'h0, 8'h8F);
    add_row(WR_LED, 8'h30, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h07, 4'h4, 4'h0, 8'h8F);
    add_row(WR_LED, 8'h36, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h04, 4'h6, 4'h0, 8'h8F);
    add_row(RD_LED, 8'h00, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h06, 4'h6, 4'h0, 8'h8F);
    add_row(WR_AUX, 8'h0B, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h00, 4'h6, 4'hB, 8'h8F);
    add_row(WR_AUX, 8'h80, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h0B, 4'h6, 4'h3, 8'h8F);
    add_row(WR_AUX, 8'hFF, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h03, 4'h6, 4'hC, 8'h8F);
    add_row(RD_AUX, 8'h00, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h0C, 4'h6, 4'hC, 8'h8F);
    // soft reset
    add_row(WR_RTE, 8'h05, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h00, 4'h6, 4'hC, 8'h8F);
    add_row(WR_RST, 8'h00, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h00, 4'h1, 4'h0, 8'h8F);
    add_row(RD_AUX, 8'h00, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h00, 4'h1, 4'h0, 8'h8F);
    add_row(RD_RTE, 8'h00, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h00, 4'h1, 4'h0, 8'h8F);
    // route sweep with sel_n low
    // miso follows the route from before the write
    add_row(WR_RTE, 8'h01, FULL, 1'b0, 1'b1, 8'h00, NONE, 8'h00, 4'h1, 4'h0, 8'h8E);
    add_row(WR_RTE, 8'h02, FULL, 1'b0, 1'b1, 8'h00, 4'd0, 8'h00, 4'h1, 4'h0, 8'h8D);
    add_row(WR_RTE, 8'h03, FULL, 1'b0, 1'b1, 8'h00, 4'd1, 8'h00, 4'h1, 4'h0, 8'h8B);
    add_row(WR_RTE, 8'h04, FULL, 1'b0, 1'b1, 8'h00, 4'd2, 8'h00, 4'h1, 4'h0, 8'h87);
    add_row(WR_RTE, 8'h05, FULL, 1'b0, 1'b1, 8'h00, 4'd3, 8'h00, 4'h1, 4'h0, 8'h9F);
    add_row(WR_RTE, 8'h06, FULL, 1'b0, 1'b1, 8'h00, 4'd4, 8'h00, 4'h1, 4'h0, 8'hAF);
    add_row(WR_RTE, 8'h07, FULL, 1'b0, 1'b1, 8'h00, 4'd5, 8'h00, 4'h1, 4'h0, 8'hCF);
    add_row(WR_RTE, 8'h08, FULL, 1'b0, 1'b1, 8'h00, 4'd6, 8'h00, 4'h1, 4'h0, 8'h0F);
    add_row(WR_RTE, 8'h09, FULL, 1'b0, 1'b1, 8'h00, 4'd7, 8'h00, 4'h1, 4'h0, 8'h8F);
    // bank read-back while sel_n high
    add_row(RD_RTE, 8'h00, FULL, 1'b1, 1'b1, 8'h00, BANK, 8'h09, 4'h1, 4'h0, 8'h8F);
    add_row(WR_RTE, 8'h03, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h09, 4'h1, 4'h0, 8'h8F);
    add_row(RD_LED, 8'h00, FULL, 1'b0, 1'b1, 8'h00, 4'd2, 8'h01, 4'h1, 4'h0, 8'h8B);
    // frames cut at 12 bits write nothing
    add_row(WR_LED, 8'h0E, CUT, 1'b1, 1'b0, 8'h00, BANK, 8'h01, 4'h1, 4'h0, 8'h8F);
    add_row(RD_LED, 8'h00, FULL, 1'b1, 1'b0, 8'h00, BANK, 8'h01, 4'h1, 4'h0, 8'h8F);
    add_row(WR_RTE, 8'h00, CUT, 1'b0, 1'b1, 8'h00, 4'd2, 8'h00, 4'h1, 4'h0, 8'h8B);
  endtask

  ////////////////////
  // main sequence

  initial
  begin
    row_t row;
    arst_n = 1'b0;
    sclk = 1'b0;
    ss_n = 1'b1;
    mosi = 1'b0;
    sel_n = 1'b1;
    periph_miso = '0;
    check_stb = 1'b0;
    row_idx = 0;
    exp_byte = '0;
    exp_led = '0;
    exp_aux = '0;
    exp_ss = '0;
    settle_err = 0;
    load_table();
    wait_cycles(16);
    arst_n = 1'b1;
    wait_cycles(4);
    for (int r = 0; r < table_q.size(); r++)
    begin
      row = table_q[r];
      row_idx = r;
      sel_n = row.sel_n;
      if (row.use_lfsr)
        draw_periph_miso(periph_miso);
      else
        periph_miso = row.fixed_miso;
      // what the host should see on miso over the data byte
      if (row.miso_src == BANK)
        exp_byte = row.exp_rd;
      else if (row.miso_src == NONE)
        exp_byte = '0;
      else
        exp_byte = {8{periph_miso[row.miso_src[2:0]]}};
      exp_led = row.exp_led;
      exp_aux = row.exp_aux;
      exp_ss = row.exp_ss;
      wait_cycles(2);
      send_frame(row.addr, row.data, row.nbits);
      wait_settle(r);
      check_stb = 1'b1;
      wait_cycles(1);
      check_stb = 1'b0;
    end
    wait_cycles(2);
    $display("rows run %0d, passed %0d, failed %0d, settle timeouts %0d", table_q.size(),
             pass_cnt, fail_cnt, settle_err);
    if (fail_cnt == 0 && settle_err == 0 && pass_cnt == table_q.size())
      $display("TESTBENCH PASSED");
    else
      $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

/* src.f */
design/spi_pkg.sv
design/regmap_pkg.sv
design/spi_frame_rx.sv
design/reg_file.sv
design/periph_route.sv
design/spi_ctrl_top.sv
verification/spi_ctrl_checker.sv
verification/spi_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the spi control block testbench with verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module spi_ctrl_tb -f src.f -o spi_ctrl_sim \
  || { echo "verilator build failed"; exit 1; }
out=$(./obj_dir/spi_ctrl_sim)
echo "$out"
echo "$out" | grep -q "TESTBENCH PASSED" && echo "simulation ok" \
  || { echo "simulation reported failure"; exit 1; }
